//--- bench/frontend_sva.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_sva (
    input wire       clk,
    input wire       rstn,
    input wire [1:0] i_id_valid,
    input wire       i_flush_br,
    input wire       i_fetch_req,
    input wire       i_buf_full
);

    // slot 2 never carries an instruction on its own
    a_no_lone_slot2: assert property (
        @(posedge clk) disable iff (!rstn)
        i_id_valid != 2'b01
    ) else $error("decode valid showed pattern 01");

    // flush empties decode on the next cycle
    a_flush_clears: assert property (
        @(posedge clk) disable iff (!rstn)
        i_flush_br |=> (i_id_valid == 2'b00)
    ) else $error("decode valid not cleared the cycle after a flush");

    // no new request while the buffer reports full
    a_no_req_when_full: assert property (
        @(posedge clk) disable iff (!rstn)
        i_buf_full |-> !i_fetch_req
    ) else $error("fetch request issued while the buffer is full");

endmodule

bind frontend_top frontend_sva u_sva (
    .clk         (clk),
    .rstn        (rstn),
    .i_id_valid  (o_id_valid),
    .i_flush_br  (i_flush_br),
    .i_fetch_req (o_fetch_req),
    .i_buf_full  (buf_full)
);

`default_nettype wire

//--- bench/tb_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_frontend
    import fe_pkg::*;
();

    localparam int N_CYCLES      = 3000;
    localparam int DRAIN_CYCLES  = 40;
    localparam int MIN_DELIVERED = N_CYCLES / 2;
    localparam int MEM_AW        = 12;

    logic              clk;
    logic              rstn;
    logic              o_fetch_req;
    logic [XLEN-1:0]   o_fetch_pc;
    logic [2*XLEN-1:0] i_fetch_line;
    logic              i_icache_miss;
    logic              i_flush_br;
    logic [XLEN-1:0]   i_redirect_pc;
    logic              i_issue_stall;
    logic [1:0]        o_id_valid;
    logic [XLEN-1:0]   o_id_pc1;
    logic [XLEN-1:0]   o_id_ir1;
    op_class_e         o_id_class1;
    logic [XLEN-1:0]   o_id_pc2;
    logic [XLEN-1:0]   o_id_ir2;
    op_class_e         o_id_class2;

    // cache contents, indexed by word address
    logic [XLEN-1:0]   mem [1 << MEM_AW];
    integer            seed;
    int                delivered;
    int                cyc;

    // request seen mid-cycle, answered at the next rising edge
    logic              req_seen;
    logic [XLEN-1:0]   req_pc_seen;

    // reference model state
    logic [XLEN-1:0]   exp_pc;
    logic              odd_pending;
    logic              quiet;
    logic              flush_prev;
    logic              stall_prev1;
    logic              stall_prev2;

    frontend_top DUT (
        .clk           (clk),
        .rstn          (rstn),
        .o_fetch_req   (o_fetch_req),
        .o_fetch_pc    (o_fetch_pc),
        .i_fetch_line  (i_fetch_line),
        .i_icache_miss (i_icache_miss),
        .i_flush_br    (i_flush_br),
        .i_redirect_pc (i_redirect_pc),
        .i_issue_stall (i_issue_stall),
        .o_id_valid    (o_id_valid),
        .o_id_pc1      (o_id_pc1),
        .o_id_ir1      (o_id_ir1),
        .o_id_class1   (o_id_class1),
        .o_id_pc2      (o_id_pc2),
        .o_id_ir2      (o_id_ir2),
        .o_id_class2   (o_id_class2)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #((N_CYCLES + 200) * 10);
        $display("watchdog expired, run did not finish within %0d ns", (N_CYCLES + 200) * 10);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog timeout");
    end

    ////////////////////////////////////////////////////////////
    // cache model and opcode rule
    ////////////////////////////////////////////////////////////

    function automatic logic [XLEN-1:0] word_at(input logic [XLEN-1:0] pc);
        return mem[pc[MEM_AW+1:2]];
    endfunction

    // low word is the aligned one
    function automatic logic [2*XLEN-1:0] line_for(input logic [XLEN-1:0] pc);
        logic [XLEN-1:0] base;
        base = {pc[XLEN-1:3], 3'b000};
        return {word_at(base + 32'd4), word_at(base)};
    endfunction

    function automatic logic [6:0] pick_opcode(input int k);
        logic [6:0] opc;
        case (k)
            0:       opc = OPC_ALU_R;
            1:       opc = OPC_ALU_I;
            2:       opc = OPC_LOAD;
            3:       opc = OPC_STORE;
            4:       opc = OPC_BRANCH;
            5:       opc = OPC_JAL;
            default: opc = OPC_JALR;
        endcase
        return opc;
    endfunction

    function automatic op_class_e expected_class(input logic [XLEN-1:0] ir);
        logic [6:0] opc;
        op_class_e  cls;
        opc = ir[6:0];
        if (opc == OPC_ALU_R || opc == OPC_ALU_I) begin
            cls = OPC_CLASS_ALU;
        end else if (opc == OPC_LOAD) begin
            cls = OPC_CLASS_LOAD;
        end else if (opc == OPC_STORE) begin
            cls = OPC_CLASS_STORE;
        end else if (opc == OPC_BRANCH) begin
            cls = OPC_CLASS_BRANCH;
        end else if (opc == OPC_JAL || opc == OPC_JALR) begin
            cls = OPC_CLASS_JUMP;
        end else begin
            cls = OPC_CLASS_OTHER;
        end
        return cls;
    endfunction

    // most words get a known opcode, the rest stay fully random
    task automatic fill_memory();
        logic [XLEN-1:0] w;
        int              k;
        int              a;
        for (a = 0; a < (1 << MEM_AW); a++) begin
            w = $random(seed);
            k = $unsigned($random(seed)) % 10;
            if (k < 7) begin
                w[6:0] = pick_opcode(k);
            end
            mem[a] = w;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic stop_on_error();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("Fail: time %0t %s pc got %08h expected %08h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_ir(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("Fail: time %0t %s ir got %08h expected %08h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_class(input op_class_e got, input op_class_e exp, input string what);
        if (got !== exp) begin
            $display("Fail: time %0t %s class got %0d expected %0d", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_valid(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail: time %0t %s valid got %b expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // one delivered slot against the program order model
    task automatic check_slot(input logic [XLEN-1:0] pc, input logic [XLEN-1:0] ir,
                              input op_class_e cls, input string what);
        check_pc(pc, exp_pc, what);
        check_ir(ir, word_at(exp_pc), what);
        check_class(cls, expected_class(word_at(exp_pc)), what);
        exp_pc    = exp_pc + 32'd4;
        delivered = delivered + 1;
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    task automatic run_cycle(input bit random_ctrl);
        logic odd;
        @(posedge clk);
        // answer the request of the cycle that just ended
        if (req_seen) begin
            i_fetch_line <= line_for(req_pc_seen);
        end else begin
            i_fetch_line <= '0;
        end
        i_icache_miss <= (($random(seed) & 7) == 0);
        if (random_ctrl) begin
            i_issue_stall <= ($unsigned($random(seed)) % 5 == 0);
            if ($unsigned($random(seed)) % 60 == 0) begin
                odd = (($random(seed) & 3) == 0);
                i_flush_br    <= 1'b1;
                i_redirect_pc <= (RESET_PC + ($random(seed) & 32'h0000_3ff8))
                                 | (odd ? 32'd4 : 32'd0);
            end else begin
                i_flush_br <= 1'b0;
            end
        end else begin
            i_issue_stall <= 1'b0;
            i_flush_br    <= 1'b0;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // monitor, sampled mid-cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        req_seen    = o_fetch_req;
        req_pc_seen = o_fetch_pc;
        if (rstn) begin
            if (o_id_valid == 2'b01) begin
                $display("Fail: time %0t slot 2 valid without slot 1", $time);
                stop_on_error();
            end
            if (flush_prev) begin
                check_valid(o_id_valid, 2'b00, "cycle after flush");
            end
            // a stall empties the buffer output, then the predecode output
            if (stall_prev2) begin
                check_valid(o_id_valid, 2'b00, "two cycles after stall");
            end
            if (o_fetch_req && DUT.buf_full) begin
                $display("fetch request issued while the buffer was full at time %0t", $time);
                stop_on_error();
            end
            // odd redirect with no stall since gives a lone slot 1
            if (odd_pending && o_id_valid != 2'b00) begin
                if (quiet) begin
                    check_valid(o_id_valid, 2'b10, "first delivery after odd redirect");
                end
                odd_pending = 1'b0;
            end
            if (o_id_valid[1]) begin
                check_slot(o_id_pc1, o_id_ir1, o_id_class1, "slot 1");
            end
            if (o_id_valid[0]) begin
                check_slot(o_id_pc2, o_id_ir2, o_id_class2, "slot 2");
            end
            stall_prev2 = stall_prev1;
            stall_prev1 = i_issue_stall;
            flush_prev  = i_flush_br;
            if (i_flush_br) begin
                exp_pc      = i_redirect_pc;
                odd_pending = i_redirect_pc[2];
                quiet       = 1'b1;
            end else if (i_issue_stall) begin
                quiet = 1'b0;
            end
        end
    end

    initial begin
        seed          = 32'he8c1_02db;
        rstn          = 1'b0;
        i_fetch_line  = '0;
        i_icache_miss = 1'b0;
        i_flush_br    = 1'b0;
        i_redirect_pc = '0;
        i_issue_stall = 1'b0;
        req_seen      = 1'b0;
        req_pc_seen   = '0;
        exp_pc        = RESET_PC;
        odd_pending   = 1'b0;
        quiet         = 1'b0;
        flush_prev    = 1'b0;
        stall_prev1   = 1'b0;
        stall_prev2   = 1'b0;
        delivered     = 0;
        fill_memory();

        repeat (5) @(posedge clk);
        rstn <= 1'b1;

        for (cyc = 0; cyc < N_CYCLES; cyc++) begin
            run_cycle(1'b1);
        end
        // let the buffer drain without stalls or flushes
        for (cyc = 0; cyc < DRAIN_CYCLES; cyc++) begin
            run_cycle(1'b0);
        end
        // last monitor sample lands before this edge
        @(posedge clk);

        if (delivered < MIN_DELIVERED) begin
            $display("too few instructions delivered, %0d of at least %0d",
                     delivered, MIN_DELIVERED);
            $display("Simulation finished: FAIL");
            $fatal(1, "delivery count too low");
        end else begin
            $display("%0d instructions delivered", delivered);
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- flist.f
logic/fe_pkg.sv
logic/fetch_pc_gen.sv
logic/inst_buffer.sv
logic/predecode.sv
logic/frontend_top.sv
bench/frontend_sva.sv
bench/tb_frontend.sv

//--- logic/fe_pkg.sv
`default_nettype none

package fe_pkg;

    ////////////////////////////////////////////////////////////
    // widths and queue geometry
    ////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int BUF_DEPTH  = 16;
    // one extra bit so a full queue is told apart from an empty one
    localparam int PTR_W      = 5;
    // entries kept free for lines still in flight when full rises
    localparam int FULL_SLACK = 6;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

    ////////////////////////////////////////////////////////////
    // major opcodes, bits 6:0 of the instruction
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_ALU_R  = 7'b0110011;
    localparam logic [6:0] OPC_ALU_I  = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // operation class handed to decode
    typedef enum logic [2:0] {
        OPC_CLASS_ALU    = 3'd0,
        OPC_CLASS_LOAD   = 3'd1,
        OPC_CLASS_STORE  = 3'd2,
        OPC_CLASS_BRANCH = 3'd3,
        OPC_CLASS_JUMP   = 3'd4,
        OPC_CLASS_OTHER  = 3'd5
    } op_class_e;

endpackage

`default_nettype wire

//--- logic/fetch_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen
    import fe_pkg::*;
(
    input  wire               clk,
    input  wire               rstn,
    input  wire               i_flush_br,
    input  wire  [XLEN-1:0]   i_redirect_pc,
    input  wire               i_buf_full,
    input  wire  [2*XLEN-1:0] i_fetch_line,
    input  wire               i_icache_miss,
    output logic              o_fetch_req,
    output logic [XLEN-1:0]   o_fetch_pc,
    output logic [XLEN-1:0]   o_pc1,
    output logic [XLEN-1:0]   o_ir1,
    output logic [XLEN-1:0]   o_pc2,
    output logic [XLEN-1:0]   o_ir2,
    output logic [1:0]        o_valid
);

    logic            run_q;
    logic [XLEN-1:0] fetch_pc;
    logic [XLEN-1:0] flight_pc;
    logic            flight_live;
    logic [XLEN-1:0] step_pc;
    logic            line_hit;
    logic            line_miss;

    // first request goes out the cycle after reset is released
    assign o_fetch_req = run_q & ~i_buf_full & ~i_flush_br;
    assign o_fetch_pc  = fetch_pc;

    // odd word start only yields the high word of the line
    assign step_pc   = fetch_pc + (fetch_pc[2] ? XLEN'(4) : XLEN'(8));
    assign line_hit  = flight_live & ~i_icache_miss;
    assign line_miss = flight_live & i_icache_miss;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            run_q       <= 1'b0;
            fetch_pc    <= RESET_PC;
            flight_pc   <= RESET_PC;
            flight_live <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (i_flush_br) begin
                // line already in flight is on the old path
                fetch_pc    <= i_redirect_pc;
                flight_live <= 1'b0;
            end else if (line_miss) begin
                // replay the missed pc, drop this cycle's request
                fetch_pc    <= flight_pc;
                flight_live <= 1'b0;
            end else if (o_fetch_req) begin
                flight_pc   <= fetch_pc;
                fetch_pc    <= step_pc;
                flight_live <= 1'b1;
            end else begin
                flight_live <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // line alignment into pc/instruction pairs
    ////////////////////////////////////////////////////////////

    always_comb begin
        o_pc1 = flight_pc;
        o_pc2 = flight_pc + XLEN'(4);
        o_ir2 = i_fetch_line[2*XLEN-1:XLEN];
        if (flight_pc[2]) begin
            o_ir1   = i_fetch_line[2*XLEN-1:XLEN];
            o_valid = line_hit ? 2'b10 : 2'b00;
        end else begin
            o_ir1   = i_fetch_line[XLEN-1:0];
            o_valid = line_hit ? 2'b11 : 2'b00;
        end
    end

endmodule

`default_nettype wire

//--- logic/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top
    import fe_pkg::*;
(
    input  wire               clk,
    input  wire               rstn,
    // instruction cache side
    output logic              o_fetch_req,
    output logic [XLEN-1:0]   o_fetch_pc,
    input  wire  [2*XLEN-1:0] i_fetch_line,
    input  wire               i_icache_miss,
    // back end control
    input  wire               i_flush_br,
    input  wire  [XLEN-1:0]   i_redirect_pc,
    input  wire               i_issue_stall,
    // decode side
    output logic [1:0]        o_id_valid,
    output logic [XLEN-1:0]   o_id_pc1,
    output logic [XLEN-1:0]   o_id_ir1,
    output op_class_e         o_id_class1,
    output logic [XLEN-1:0]   o_id_pc2,
    output logic [XLEN-1:0]   o_id_ir2,
    output op_class_e         o_id_class2
);

    logic [XLEN-1:0] fetch_pc1;
    logic [XLEN-1:0] fetch_ir1;
    logic [XLEN-1:0] fetch_pc2;
    logic [XLEN-1:0] fetch_ir2;
    logic [1:0]      fetch_valid;

    logic            buf_full;
    logic [XLEN-1:0] buf_pc1;
    logic [XLEN-1:0] buf_ir1;
    logic [XLEN-1:0] buf_pc2;
    logic [XLEN-1:0] buf_ir2;
    logic [1:0]      buf_valid;

    fetch_pc_gen u_fetch (
        .clk           (clk),
        .rstn          (rstn),
        .i_flush_br    (i_flush_br),
        .i_redirect_pc (i_redirect_pc),
        .i_buf_full    (buf_full),
        .i_fetch_line  (i_fetch_line),
        .i_icache_miss (i_icache_miss),
        .o_fetch_req   (o_fetch_req),
        .o_fetch_pc    (o_fetch_pc),
        .o_pc1         (fetch_pc1),
        .o_ir1         (fetch_ir1),
        .o_pc2         (fetch_pc2),
        .o_ir2         (fetch_ir2),
        .o_valid       (fetch_valid)
    );

    inst_buffer u_buffer (
        .clk     (clk),
        .rstn    (rstn),
        .i_pc1   (fetch_pc1),
        .i_ir1   (fetch_ir1),
        .i_pc2   (fetch_pc2),
        .i_ir2   (fetch_ir2),
        .i_valid (fetch_valid),
        .i_flush (i_flush_br),
        .i_stall (i_issue_stall),
        .o_pc1   (buf_pc1),
        .o_ir1   (buf_ir1),
        .o_pc2   (buf_pc2),
        .o_ir2   (buf_ir2),
        .o_valid (buf_valid),
        .o_full  (buf_full)
    );

    predecode u_predecode (
        .clk      (clk),
        .rstn     (rstn),
        .i_flush  (i_flush_br),
        .i_pc1    (buf_pc1),
        .i_ir1    (buf_ir1),
        .i_pc2    (buf_pc2),
        .i_ir2    (buf_ir2),
        .i_valid  (buf_valid),
        .o_valid  (o_id_valid),
        .o_pc1    (o_id_pc1),
        .o_ir1    (o_id_ir1),
        .o_class1 (o_id_class1),
        .o_pc2    (o_id_pc2),
        .o_ir2    (o_id_ir2),
        .o_class2 (o_id_class2)
    );

endmodule

`default_nettype wire

//--- logic/inst_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module inst_buffer
    import fe_pkg::*;
(
    input  wire             clk,
    input  wire             rstn,
    input  wire  [XLEN-1:0] i_pc1,
    input  wire  [XLEN-1:0] i_ir1,
    input  wire  [XLEN-1:0] i_pc2,
    input  wire  [XLEN-1:0] i_ir2,
    input  wire  [1:0]      i_valid,
    input  wire             i_flush,
    input  wire             i_stall,
    output logic [XLEN-1:0] o_pc1,
    output logic [XLEN-1:0] o_ir1,
    output logic [XLEN-1:0] o_pc2,
    output logic [XLEN-1:0] o_ir2,
    output logic [1:0]      o_valid,
    output logic            o_full
);

    logic [XLEN-1:0]  pc_mem [BUF_DEPTH];
    logic [XLEN-1:0]  ir_mem [BUF_DEPTH];

    // head is the oldest entry, tail the next free slot
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] head_p1;
    logic [PTR_W-1:0] tail_p1;

    logic [PTR_W-1:0] stored;
    logic [PTR_W-1:0] in_cnt;
    logic [PTR_W-1:0] total;
    logic [PTR_W-1:0] out_cnt;
    logic [PTR_W-1:0] stored_next;

    logic             wr1;
    logic             wr2;
    logic [XLEN-1:0]  sel_pc1;
    logic [XLEN-1:0]  sel_ir1;
    logic [XLEN-1:0]  sel_pc2;
    logic [XLEN-1:0]  sel_ir2;

    ////////////////////////////////////////////////////////////
    // occupancy
    ////////////////////////////////////////////////////////////

    assign wr1 = i_valid[1];
    assign wr2 = i_valid[1] & i_valid[0];

    assign head_p1 = head + PTR_W'(1);
    assign tail_p1 = tail + PTR_W'(1);

    // pointer difference wraps in PTR_W bits
    assign stored  = tail - head;
    assign in_cnt  = wr2 ? PTR_W'(2) : (wr1 ? PTR_W'(1) : PTR_W'(0));
    assign total   = stored + in_cnt;
    assign out_cnt = (total >= PTR_W'(2)) ? PTR_W'(2) : total;

    always_comb begin
        if (i_flush) begin
            stored_next = '0;
        end else if (i_stall) begin
            stored_next = total;
        end else begin
            stored_next = total - out_cnt;
        end
    end

    ////////////////////////////////////////////////////////////
    // storage, incoming pairs are always queued at tail
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_flush && wr1) begin
            pc_mem[tail[PTR_W-2:0]] <= i_pc1;
            ir_mem[tail[PTR_W-2:0]] <= i_ir1;
        end
        if (!i_flush && wr2) begin
            pc_mem[tail_p1[PTR_W-2:0]] <= i_pc2;
            ir_mem[tail_p1[PTR_W-2:0]] <= i_ir2;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head <= '0;
            tail <= '0;
        end else if (i_flush) begin
            head <= '0;
            tail <= '0;
        end else begin
            tail <= tail + in_cnt;
            if (!i_stall) begin
                head <= head + out_cnt;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // read side with bypass of incoming pairs
    ////////////////////////////////////////////////////////////

    // slot order is stored entries first, then incoming slot 1, then slot 2
    always_comb begin
        sel_pc1 = i_pc1;
        sel_ir1 = i_ir1;
        sel_pc2 = i_pc2;
        sel_ir2 = i_ir2;
        if (stored >= PTR_W'(2)) begin
            sel_pc1 = pc_mem[head[PTR_W-2:0]];
            sel_ir1 = ir_mem[head[PTR_W-2:0]];
            sel_pc2 = pc_mem[head_p1[PTR_W-2:0]];
            sel_ir2 = ir_mem[head_p1[PTR_W-2:0]];
        end else if (stored == PTR_W'(1)) begin
            sel_pc1 = pc_mem[head[PTR_W-2:0]];
            sel_ir1 = ir_mem[head[PTR_W-2:0]];
            sel_pc2 = i_pc1;
            sel_ir2 = i_ir1;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_flush && !i_stall) begin
            o_pc1 <= sel_pc1;
            o_ir1 <= sel_ir1;
            o_pc2 <= sel_pc2;
            o_ir2 <= sel_ir2;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_valid <= 2'b00;
        end else if (i_flush || i_stall) begin
            o_valid <= 2'b00;
        end else if (total == PTR_W'(0)) begin
            o_valid <= 2'b00;
        end else if (total == PTR_W'(1)) begin
            o_valid <= 2'b10;
        end else begin
            o_valid <= 2'b11;
        end
    end

    // early full, judged on next cycle's occupancy
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_full <= 1'b0;
        end else begin
            o_full <= (stored_next >= PTR_W'(BUF_DEPTH - FULL_SLACK));
        end
    end

endmodule

`default_nettype wire

//--- logic/predecode.sv
`timescale 1ns/1ps
`default_nettype none

module predecode
    import fe_pkg::*;
(
    input  wire             clk,
    input  wire             rstn,
    input  wire             i_flush,
    input  wire  [XLEN-1:0] i_pc1,
    input  wire  [XLEN-1:0] i_ir1,
    input  wire  [XLEN-1:0] i_pc2,
    input  wire  [XLEN-1:0] i_ir2,
    input  wire  [1:0]      i_valid,
    output logic [1:0]      o_valid,
    output logic [XLEN-1:0] o_pc1,
    output logic [XLEN-1:0] o_ir1,
    output op_class_e       o_class1,
    output logic [XLEN-1:0] o_pc2,
    output logic [XLEN-1:0] o_ir2,
    output op_class_e       o_class2
);

    // class from the major opcode only
    function automatic op_class_e classify(input logic [XLEN-1:0] ir);
        op_class_e cls;
        case (ir[6:0])
            OPC_ALU_R, OPC_ALU_I: cls = OPC_CLASS_ALU;
            OPC_LOAD:             cls = OPC_CLASS_LOAD;
            OPC_STORE:            cls = OPC_CLASS_STORE;
            OPC_BRANCH:           cls = OPC_CLASS_BRANCH;
            OPC_JAL, OPC_JALR:    cls = OPC_CLASS_JUMP;
            default:              cls = OPC_CLASS_OTHER;
        endcase
        return cls;
    endfunction

    always_ff @(posedge clk) begin
        if (i_valid[1]) begin
            o_pc1    <= i_pc1;
            o_ir1    <= i_ir1;
            o_class1 <= classify(i_ir1);
        end
        if (i_valid[0]) begin
            o_pc2    <= i_pc2;
            o_ir2    <= i_ir2;
            o_class2 <= classify(i_ir2);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_valid <= 2'b00;
        end else if (i_flush) begin
            o_valid <= 2'b00;
        end else begin
            o_valid <= i_valid;
        end
    end

endmodule

`default_nettype wire
